/* Makefile */
VERILATOR  ?= verilator
TOP        := demodBoardTb
RTL_TOP    := demodBoardTop
FILELIST   := build.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
rtl/demodBusPkg.sv
rtl/demodDataPkg.sv
rtl/apbRegDecode.sv
rtl/topRegs.sv
rtl/clkDataOutput.sv
rtl/dacOutputs.sv
rtl/demodBoardTop.sv
tb/demodBoardTb.sv

/* rtl/apbRegDecode.sv */
`timescale 1ns/1ps

module apbRegDecode (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  demodBusPkg::addrT      paddr,
    input  demodBusPkg::dataT      pwdata,
    output demodBusPkg::dataT      prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   topSel,
    output logic                   cand0Sel,
    output logic                   cand1Sel,
    output logic                   regWrite,
    output demodBusPkg::regOffsetT regOffset,
    output demodBusPkg::dataT      regWdata,
    input  demodBusPkg::dataT      topRdata,
    input  demodBusPkg::dataT      cand0Rdata,
    input  demodBusPkg::dataT      cand1Rdata
);

    import demodBusPkg::*;

    logic accessPhase;
    logic mapped;

    assign accessPhase = psel && penable;

    // Region decode on the upper address byte
    assign topSel   = psel && (paddr[15:8] == REGION_TOP[15:8]);
    assign cand0Sel = psel && (paddr[15:8] == REGION_CAND0[15:8]);
    assign cand1Sel = psel && (paddr[15:8] == REGION_CAND1[15:8]);
    assign mapped   = topSel || cand0Sel || cand1Sel;

    // Writes land on the edge that closes the access phase
    assign regWrite  = accessPhase && pwrite && mapped;
    assign regOffset = paddr[7:0];
    assign regWdata  = pwdata;

    // ****************************************
    // Read data mux
    // ****************************************
    always_comb begin
        case (paddr[15:8])
            REGION_TOP[15:8]:   prdata = topRdata;
            REGION_CAND0[15:8]: prdata = cand0Rdata;
            REGION_CAND1[15:8]: prdata = cand1Rdata;
            default:            prdata = '0;
        endcase
    end

    // No wait states
    assign pready  = accessPhase;
    assign pslverr = accessPhase && !mapped;

    // Error response only ever inside a transfer
    assert property (@(posedge clk) disable iff (!rstN)
        pslverr |-> (psel && penable && $past(psel)))
        else $error("pslverr outside an APB access phase");

endmodule

/* rtl/clkDataOutput.sv */
`timescale 1ns/1ps

module clkDataOutput #(
    parameter demodBusPkg::addrT regBase = demodBusPkg::REGION_CAND0
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   regSel,
    input  logic                   regWrite,
    input  demodBusPkg::regOffsetT regOffset,
    input  demodBusPkg::dataT      regWdata,
    output demodBusPkg::dataT      regRdata,
    input  logic                   iSymEn,
    input  logic                   iBit,
    input  logic                   qSymEn,
    input  logic                   qBit,
    input  logic                   dec0Ch0ClkEn,
    input  logic                   dec0Ch0Data,
    input  logic                   dec0Ch1ClkEn,
    input  logic                   dec0Ch1Data,
    output logic                   chClkOut,
    output logic                   chDataOut
);

    import demodBusPkg::*;
    import demodDataPkg::*;

    cdSourceT source;
    logic     selEn;
    logic     selBit;
    logic     strobeQ;
    logic     bitQ;
    logic     clkPending;

    // ****************************************
    // Source select register
    // ****************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            source <= CD_SRC_LEGACY_I;
        end else if (regSel && regWrite && (regOffset == OFS_SOURCE)) begin
            source <= cdSourceT'(regWdata[3:0]);
        end
    end

    assign regRdata = (regOffset == OFS_SOURCE) ? {28'd0, source} : '0;

    // Stream mux
    always_comb begin
        case (source)
            CD_SRC_LEGACY_Q: begin
                selEn  = qSymEn;
                selBit = qBit;
            end
            CD_SRC_DEC0_CH0: begin
                selEn  = dec0Ch0ClkEn;
                selBit = dec0Ch0Data;
            end
            CD_SRC_DEC0_CH1: begin
                selEn  = dec0Ch1ClkEn;
                selBit = dec0Ch1Data;
            end
            default: begin
                selEn  = iSymEn;
                selBit = iBit;
            end
        endcase
    end

    // Selected bit, aligned with the sampled strobe
    always_ff @(posedge clk) begin
        bitQ <= selBit;
    end

    // Sample strobe, update data, then clock one cycle behind
    always_ff @(posedge clk) begin
        if (!rstN) begin
            strobeQ    <= 1'b0;
            clkPending <= 1'b0;
            chDataOut  <= 1'b0;
            chClkOut   <= 1'b0;
        end else begin
            strobeQ    <= selEn;
            clkPending <= strobeQ;
            chClkOut   <= clkPending;
            if (strobeQ) begin
                chDataOut <= bitQ;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) chClkOut |=> !chClkOut)
        else $error("Channel at %h: output clock wider than one cycle", regBase);

endmodule

/* rtl/dacOutputs.sv */
`timescale 1ns/1ps

module dacOutputs (
    input  logic                    clk,
    input  logic                    rstN,
    input  demodDataPkg::adcWordT   adc0,
    input  demodDataPkg::sampleT    demodDac0Data,
    input  demodDataPkg::sampleT    demodDac1Data,
    input  demodDataPkg::dacSourceT dac0Source,
    input  demodDataPkg::dacSourceT dac1Source,
    output demodDataPkg::dacWordT   dac0Data,
    output demodDataPkg::dacWordT   dac1Data
);

    import demodDataPkg::*;

    adcWordT   adcReg;
    sampleT    adcSample;
    sampleT    demodIn [2];
    dacSourceT srcSel [2];
    sampleT    muxSample [2];
    dacWordT   dacWord [2];

    // ****************************************
    // ADC reclock
    // ****************************************
    // Offset binary to two's complement, scaled up to 18 bits
    always_ff @(posedge clk) begin
        adcReg    <= adc0;
        adcSample <= sampleT'({~adcReg[13], adcReg[12:0], 4'b0000});
    end

    assign demodIn[0] = demodDac0Data;
    assign demodIn[1] = demodDac1Data;
    assign srcSel[0]  = dac0Source;
    assign srcSel[1]  = dac1Source;

    // Per DAC source mux and offset binary format
    for (genvar i = 0; i < 2; i++) begin : gDac
        always_ff @(posedge clk) begin
            if (!rstN) begin
                muxSample[i] <= '0;
                dacWord[i]   <= 14'h2000;
            end else begin
                case (srcSel[i])
                    DAC_SRC_DEMOD: muxSample[i] <= demodIn[i];
                    DAC_SRC_ADC:   muxSample[i] <= adcSample;
                    default:       muxSample[i] <= '0;
                endcase
                dacWord[i] <= {~muxSample[i][17], muxSample[i][16:4]};
            end
        end
    end

    assign dac0Data = dacWord[0];
    assign dac1Data = dacWord[1];

endmodule

/* rtl/demodBoardTop.sv */
`timescale 1ns/1ps

module demodBoardTop (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  demodBusPkg::addrT     paddr,
    input  demodBusPkg::dataT     pwdata,
    output demodBusPkg::dataT     prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  demodDataPkg::adcWordT adc0,
    input  logic                  iSymEn,
    input  logic                  iBit,
    input  logic                  qSymEn,
    input  logic                  qBit,
    input  logic                  dec0Ch0ClkEn,
    input  logic                  dec0Ch0Data,
    input  logic                  dec0Ch1ClkEn,
    input  logic                  dec0Ch1Data,
    input  demodDataPkg::sampleT  demodDac0Data,
    input  demodDataPkg::sampleT  demodDac1Data,
    input  logic                  timingLock,
    input  logic                  carrierLock,
    output demodDataPkg::dacWordT dac0Data,
    output demodDataPkg::dacWordT dac1Data,
    output logic                  ch0ClkOut,
    output logic                  ch0DataOut,
    output logic                  ch1ClkOut,
    output logic                  ch1DataOut,
    output logic                  lockLed0n,
    output logic                  lockLed1n,
    output logic                  reboot,
    output logic [23:0]           rebootAddress
);

    import demodBusPkg::*;
    import demodDataPkg::*;

    logic      topSel;
    logic      cand0Sel;
    logic      cand1Sel;
    logic      regWrite;
    regOffsetT regOffset;
    dataT      regWdata;
    dataT      topRdata;
    dataT      cand0Rdata;
    dataT      cand1Rdata;
    dacSourceT dac0Source;
    dacSourceT dac1Source;

    // ****************************************
    // Register bus
    // ****************************************
    apbRegDecode apbRegDecode_inst (
        .clk(clk), .rstN(rstN),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .topSel(topSel), .cand0Sel(cand0Sel), .cand1Sel(cand1Sel),
        .regWrite(regWrite), .regOffset(regOffset), .regWdata(regWdata),
        .topRdata(topRdata), .cand0Rdata(cand0Rdata), .cand1Rdata(cand1Rdata)
    );

    topRegs topRegs_inst (
        .clk(clk), .rstN(rstN),
        .regSel(topSel), .regWrite(regWrite),
        .regOffset(regOffset), .regWdata(regWdata), .regRdata(topRdata),
        .timingLock(timingLock), .carrierLock(carrierLock),
        .reboot(reboot), .rebootAddress(rebootAddress),
        .dac0Source(dac0Source), .dac1Source(dac1Source),
        .lockLed0n(lockLed0n), .lockLed1n(lockLed1n)
    );

    // ****************************************
    // Clock and data outputs
    // ****************************************
    clkDataOutput #(.regBase(REGION_CAND0)) cAndD0 (
        .clk(clk), .rstN(rstN),
        .regSel(cand0Sel), .regWrite(regWrite),
        .regOffset(regOffset), .regWdata(regWdata), .regRdata(cand0Rdata),
        .iSymEn(iSymEn), .iBit(iBit), .qSymEn(qSymEn), .qBit(qBit),
        .dec0Ch0ClkEn(dec0Ch0ClkEn), .dec0Ch0Data(dec0Ch0Data),
        .dec0Ch1ClkEn(dec0Ch1ClkEn), .dec0Ch1Data(dec0Ch1Data),
        .chClkOut(ch0ClkOut), .chDataOut(ch0DataOut)
    );

    clkDataOutput #(.regBase(REGION_CAND1)) cAndD1 (
        .clk(clk), .rstN(rstN),
        .regSel(cand1Sel), .regWrite(regWrite),
        .regOffset(regOffset), .regWdata(regWdata), .regRdata(cand1Rdata),
        .iSymEn(iSymEn), .iBit(iBit), .qSymEn(qSymEn), .qBit(qBit),
        .dec0Ch0ClkEn(dec0Ch0ClkEn), .dec0Ch0Data(dec0Ch0Data),
        .dec0Ch1ClkEn(dec0Ch1ClkEn), .dec0Ch1Data(dec0Ch1Data),
        .chClkOut(ch1ClkOut), .chDataOut(ch1DataOut)
    );

    // DAC paths
    dacOutputs dacOutputs_inst (
        .clk(clk), .rstN(rstN),
        .adc0(adc0),
        .demodDac0Data(demodDac0Data), .demodDac1Data(demodDac1Data),
        .dac0Source(dac0Source), .dac1Source(dac1Source),
        .dac0Data(dac0Data), .dac1Data(dac1Data)
    );

endmodule

/* rtl/demodBusPkg.sv */
package demodBusPkg;

    // ****************************************
    // Bus types
    // ****************************************
    typedef logic [15:0] addrT;
    typedef logic [31:0] dataT;
    typedef logic [7:0]  regOffsetT;

    // ****************************************
    // Address map
    // ****************************************
    // Region picked by the upper address byte, 256 bytes each
    localparam addrT REGION_TOP   = 16'h0000;
    localparam addrT REGION_CAND0 = 16'h0100;
    localparam addrT REGION_CAND1 = 16'h0200;

    // Build version
    localparam dataT VER_NUMBER = 32'd454;

    // Top register offsets
    localparam regOffsetT OFS_VERSION    = 8'h00;
    localparam regOffsetT OFS_BOOT_ADDR  = 8'h04;
    localparam regOffsetT OFS_REBOOT     = 8'h08;
    localparam regOffsetT OFS_DAC_SELECT = 8'h0C;
    localparam regOffsetT OFS_STATUS     = 8'h10;

    // Clock/data channel offsets
    localparam regOffsetT OFS_SOURCE = 8'h00;

endpackage

/* rtl/demodDataPkg.sv */
package demodDataPkg;

    // ****************************************
    // Sample and word types
    // ****************************************
    // Demod samples, full scale signed
    typedef logic signed [17:0] sampleT;

    // Converter words, offset binary
    typedef logic [13:0] adcWordT;
    typedef logic [13:0] dacWordT;

    // ****************************************
    // Source selects
    // ****************************************
    // Unlisted codes fall back to midscale
    typedef enum logic [2:0] {
        DAC_SRC_DEMOD    = 3'd0,
        DAC_SRC_ADC      = 3'd1,
        DAC_SRC_MIDSCALE = 3'd2
    } dacSourceT;

    // Unlisted codes fall back to legacy I
    typedef enum logic [3:0] {
        CD_SRC_LEGACY_I  = 4'd0,
        CD_SRC_LEGACY_Q  = 4'd1,
        CD_SRC_DEC0_CH0  = 4'd2,
        CD_SRC_DEC0_CH1  = 4'd3
    } cdSourceT;

endpackage

/* rtl/topRegs.sv */
`timescale 1ns/1ps

module topRegs (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    regSel,
    input  logic                    regWrite,
    input  demodBusPkg::regOffsetT  regOffset,
    input  demodBusPkg::dataT       regWdata,
    output demodBusPkg::dataT       regRdata,
    input  logic                    timingLock,
    input  logic                    carrierLock,
    output logic                    reboot,
    output logic [23:0]             rebootAddress,
    output demodDataPkg::dacSourceT dac0Source,
    output demodDataPkg::dacSourceT dac1Source,
    output logic                    lockLed0n,
    output logic                    lockLed1n
);

    import demodBusPkg::*;
    import demodDataPkg::*;

    logic       wrEn;
    logic [1:0] lockSync;

    assign wrEn = regSel && regWrite;

    // ****************************************
    // Control registers
    // ****************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rebootAddress <= '0;
            reboot        <= 1'b0;
            dac0Source    <= DAC_SRC_DEMOD;
            dac1Source    <= DAC_SRC_DEMOD;
            lockSync      <= '0;
        end else begin
            // Single cycle strobe
            reboot   <= wrEn && (regOffset == OFS_REBOOT) && regWdata[0];
            lockSync <= {carrierLock, timingLock};
            if (wrEn && (regOffset == OFS_BOOT_ADDR)) begin
                rebootAddress <= regWdata[23:0];
            end
            if (wrEn && (regOffset == OFS_DAC_SELECT)) begin
                dac0Source <= dacSourceT'(regWdata[2:0]);
                dac1Source <= dacSourceT'(regWdata[6:4]);
            end
        end
    end

    // LEDs are active low
    assign lockLed0n = !lockSync[0];
    assign lockLed1n = !lockSync[1];

    always_comb begin
        case (regOffset)
            OFS_VERSION:    regRdata = VER_NUMBER;
            OFS_BOOT_ADDR:  regRdata = {8'h00, rebootAddress};
            OFS_DAC_SELECT: regRdata = {25'd0, dac1Source, 1'b0, dac0Source};
            OFS_STATUS:     regRdata = {30'd0, lockSync};
            default:        regRdata = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rstN) reboot |=> !reboot)
        else $error("reboot held for more than one cycle");

endmodule

/* tb/demodBoardTb.sv */
`timescale 1ns/1ps

module demodBoardTb;

    import demodBusPkg::*;
    import demodDataPkg::*;

    // Test lengths in clock cycles, rough upper estimates
    localparam int DAC_RUN     = 1000;
    localparam int LOCK_RUN    = 500;
    localparam int TEST_CYCLES = 40 + 40 + (DAC_RUN + 60) + 4 * (12 + 4 * 4) + (LOCK_RUN + 40);
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

    logic        clk = 1'b0;
    logic        rstN;
    logic        psel, penable, pwrite;
    addrT        paddr;
    dataT        pwdata, prdata;
    logic        pready, pslverr;
    adcWordT     adc0;
    // Stream index matches the channel source code
    logic [3:0]  symEn, symBit;
    sampleT      demodDac0Data, demodDac1Data;
    logic        timingLock, carrierLock;
    dacWordT     dac0Data, dac1Data;
    logic        ch0ClkOut, ch0DataOut, ch1ClkOut, ch1DataOut;
    logic        lockLed0n, lockLed1n, reboot;
    logic [23:0] rebootAddress;

    logic [31:0] rngState = 32'h5b689b43;
    int          checkCount = 0;
    int          valueErrors = 0;
    int          propErrors = 0;
    int          cycleCount = 0;
    adcWordT     adcHist [4];
    sampleT      demod1Hist [2];

    demodBoardTop demodBoardTop_inst (
        .clk(clk), .rstN(rstN),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .adc0(adc0),
        .iSymEn(symEn[0]), .iBit(symBit[0]), .qSymEn(symEn[1]), .qBit(symBit[1]),
        .dec0Ch0ClkEn(symEn[2]), .dec0Ch0Data(symBit[2]),
        .dec0Ch1ClkEn(symEn[3]), .dec0Ch1Data(symBit[3]),
        .demodDac0Data(demodDac0Data), .demodDac1Data(demodDac1Data),
        .timingLock(timingLock), .carrierLock(carrierLock),
        .dac0Data(dac0Data), .dac1Data(dac1Data),
        .ch0ClkOut(ch0ClkOut), .ch0DataOut(ch0DataOut),
        .ch1ClkOut(ch1ClkOut), .ch1DataOut(ch1DataOut),
        .lockLed0n(lockLed0n), .lockLed1n(lockLed1n),
        .reboot(reboot), .rebootAddress(rebootAddress)
    );

    always begin
        #4 clk = ~clk;
    end

    // Input history for the DAC latency checks
    always @(posedge clk) begin
        adcHist[0]    <= adc0;
        adcHist[1]    <= adcHist[0];
        adcHist[2]    <= adcHist[1];
        adcHist[3]    <= adcHist[2];
        demod1Hist[0] <= demodDac1Data;
        demod1Hist[1] <= demod1Hist[0];
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without reaching the end", cycleCount);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ****************************************
    // Helpers
    // ****************************************
    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic addrT regAddr(input addrT base, input regOffsetT ofs);
        return base | {8'h00, ofs};
    endfunction

    // Offset binary ADC code to a sample with 4 fraction bits
    function automatic int adcToSample(input adcWordT w);
        return (int'(w) - 8192) * 16;
    endfunction

    // Top 14 bits of the sample, shifted to offset binary
    function automatic dacWordT sampleToDac(input int s);
        return dacWordT'((s >>> 4) + 8192);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            valueErrors++;
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic propertyFailed(input string what);
        propErrors++;
        $display("Property violated at %0t: %s", $time, what);
    endtask

    // Setup cycle, then access until pready
    task automatic apbTransfer(input logic write, input addrT addr, input dataT wdata,
                               output dataT rdata, output logic slvErr);
        int waitCount;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable   = 1'b1;
        waitCount = 0;
        #2;
        while (!pready && waitCount < 16) begin
            @(negedge clk);
            #2;
            waitCount++;
        end
        if (!pready) begin
            valueErrors++;
            $display("APB transfer to %h never got pready", addr);
        end
        rdata  = prdata;
        slvErr = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic writeReg(input addrT addr, input dataT data, input logic expErr);
        dataT rd;
        logic err;
        apbTransfer(1'b1, addr, data, rd, err);
        checkValue("pslverr", 32'(expErr), 32'(err));
    endtask

    task automatic readCheck(input addrT addr, input dataT expData, input logic expErr);
        dataT rd;
        logic err;
        apbTransfer(1'b0, addr, '0, rd, err);
        checkValue("prdata", expData, rd);
        checkValue("pslverr", 32'(expErr), 32'(err));
    endtask

    // One strobe on a stream, then both channels over the following cycles
    task automatic pulseStream(input int stream, input int src0, input int src1);
        logic [31:0] r;
        logic        value;
        logic        hit0, hit1;
        logic        prev0, prev1;
        r      = nextRandom();
        value  = r[0];
        hit0   = (src0 == stream);
        hit1   = (src1 == stream);
        prev0  = ch0DataOut;
        prev1  = ch1DataOut;
        symEn  = '0;
        symEn[stream] = 1'b1;
        symBit = r[4:1];
        symBit[stream] = value;
        @(negedge clk);
        symEn  = '0;
        symBit = r[8:5];
        @(negedge clk);
        checkValue("ch0DataOut", 32'(hit0 ? value : prev0), 32'(ch0DataOut));
        checkValue("ch1DataOut", 32'(hit1 ? value : prev1), 32'(ch1DataOut));
        checkValue("ch0ClkOut", 32'h0, 32'(ch0ClkOut));
        checkValue("ch1ClkOut", 32'h0, 32'(ch1ClkOut));
        @(negedge clk);
        checkValue("ch0ClkOut", 32'(hit0), 32'(ch0ClkOut));
        checkValue("ch1ClkOut", 32'(hit1), 32'(ch1ClkOut));
        @(negedge clk);
        checkValue("ch0ClkOut", 32'h0, 32'(ch0ClkOut));
        checkValue("ch1ClkOut", 32'h0, 32'(ch1ClkOut));
    endtask

    // ****************************************
    // Timing properties
    // ****************************************
    assert property (@(posedge clk) disable iff (!rstN) pslverr |-> (psel && penable))
        else propertyFailed("pslverr high outside an access phase");
    assert property (@(posedge clk) disable iff (!rstN) pready == (psel && penable))
        else propertyFailed("pready does not follow the access phase");
    assert property (@(posedge clk) disable iff (!rstN) $rose(reboot) |=> !reboot)
        else propertyFailed("reboot longer than one cycle");
    assert property (@(posedge clk) disable iff (!rstN) ch0ClkOut |=> !ch0ClkOut)
        else propertyFailed("ch0ClkOut longer than one cycle");
    assert property (@(posedge clk) disable iff (!rstN) ch1ClkOut |=> !ch1ClkOut)
        else propertyFailed("ch1ClkOut longer than one cycle");
    assert property (@(posedge clk) disable iff (!rstN) ch0ClkOut |-> $stable(ch0DataOut))
        else propertyFailed("ch0DataOut moved while its clock was high");
    assert property (@(posedge clk) disable iff (!rstN)
        $past(rstN) |-> (lockLed0n == !$past(timingLock) && lockLed1n == !$past(carrierLock)))
        else propertyFailed("lock LEDs do not follow the lock inputs");

    // ****************************************
    // Stimulus
    // ****************************************
    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        rstN = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        adc0 = '0;
        symEn = '0;
        symBit = '0;
        demodDac0Data = '0;
        demodDac1Data = '0;
        timingLock = 1'b0;
        carrierLock = 1'b0;
        repeat (8) @(negedge clk);
        rstN = 1'b1;

        // Reset values and decode
        checkValue("dac0Data", 32'h2000, 32'(dac0Data));
        checkValue("dac1Data", 32'h2000, 32'(dac1Data));
        checkValue("lockLed0n", 32'h1, 32'(lockLed0n));
        checkValue("lockLed1n", 32'h1, 32'(lockLed1n));
        checkValue("ch0ClkOut", 32'h0, 32'(ch0ClkOut));
        checkValue("ch0DataOut", 32'h0, 32'(ch0DataOut));
        checkValue("ch1ClkOut", 32'h0, 32'(ch1ClkOut));
        checkValue("ch1DataOut", 32'h0, 32'(ch1DataOut));
        checkValue("reboot", 32'h0, 32'(reboot));
        checkValue("rebootAddress", 32'h0, 32'(rebootAddress));
        readCheck(regAddr(REGION_TOP, OFS_VERSION), 32'd454, 1'b0);
        readCheck(16'h0400, 32'h0, 1'b1);
        writeReg(16'h0400, 32'h3, 1'b1);
        readCheck(regAddr(REGION_CAND0, OFS_SOURCE), 32'h0, 1'b0);

        // Boot address and reboot strobe
        r = nextRandom();
        writeReg(regAddr(REGION_TOP, OFS_BOOT_ADDR), r, 1'b0);
        checkValue("rebootAddress", 32'(r[23:0]), 32'(rebootAddress));
        readCheck(regAddr(REGION_TOP, OFS_BOOT_ADDR), {8'h00, r[23:0]}, 1'b0);
        checkValue("reboot", 32'h0, 32'(reboot));
        writeReg(regAddr(REGION_TOP, OFS_REBOOT), 32'h1, 1'b0);
        checkValue("reboot", 32'h1, 32'(reboot));
        @(negedge clk);
        checkValue("reboot", 32'h0, 32'(reboot));
        writeReg(regAddr(REGION_TOP, OFS_REBOOT), 32'h0, 1'b0);
        checkValue("reboot", 32'h0, 32'(reboot));

        // DAC0 from the ADC, DAC1 from the demod
        writeReg(regAddr(REGION_TOP, OFS_DAC_SELECT), 32'h01, 1'b0);
        readCheck(regAddr(REGION_TOP, OFS_DAC_SELECT), 32'h01, 1'b0);
        for (int i = 0; i < DAC_RUN; i++) begin
            if (i >= 4) begin
                checkValue("dac0Data", 32'(sampleToDac(adcToSample(adcHist[3]))),
                           32'(dac0Data));
                checkValue("dac1Data", 32'(sampleToDac(int'(demod1Hist[1]))), 32'(dac1Data));
            end
            r  = nextRandom();
            r2 = nextRandom();
            adc0          = r[13:0];
            demodDac0Data = r[31:14];
            demodDac1Data = r2[17:0];
            @(negedge clk);
        end

        // Midscale, and an unlisted code on dac0
        writeReg(regAddr(REGION_TOP, OFS_DAC_SELECT), 32'h27, 1'b0);
        readCheck(regAddr(REGION_TOP, OFS_DAC_SELECT), 32'h27, 1'b0);
        repeat (3) begin
            r = nextRandom();
            adc0 = r[13:0];
            demodDac1Data = r[31:14];
            @(negedge clk);
        end
        checkValue("dac0Data", 32'h2000, 32'(dac0Data));
        checkValue("dac1Data", 32'h2000, 32'(dac1Data));

        // Every source on both channels, ch1 one code ahead of ch0
        for (int s = 0; s < 4; s++) begin
            writeReg(regAddr(REGION_CAND0, OFS_SOURCE), 32'(s), 1'b0);
            writeReg(regAddr(REGION_CAND1, OFS_SOURCE), 32'((s + 1) % 4), 1'b0);
            readCheck(regAddr(REGION_CAND0, OFS_SOURCE), 32'(s), 1'b0);
            readCheck(regAddr(REGION_CAND1, OFS_SOURCE), 32'((s + 1) % 4), 1'b0);
            for (int j = 0; j < 4; j++) begin
                pulseStream(j, s, (s + 1) % 4);
            end
        end

        // Lock inputs to LEDs and status
        for (int i = 0; i < LOCK_RUN; i++) begin
            r = nextRandom();
            timingLock  = r[0];
            carrierLock = r[1];
            @(negedge clk);
            checkValue("lockLed0n", 32'(!timingLock), 32'(lockLed0n));
            checkValue("lockLed1n", 32'(!carrierLock), 32'(lockLed1n));
            if (i % 50 == 0) begin
                readCheck(regAddr(REGION_TOP, OFS_STATUS), {30'd0, carrierLock, timingLock},
                          1'b0);
            end
        end

        $display("Checks: %0d, value errors: %0d, property errors: %0d",
                 checkCount, valueErrors, propErrors);
        if (valueErrors == 0 && propErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
